/* main_mem.sv */
`timescale 1ns/1ps

module main_mem (
    input  logic                clk,
    input  logic                init,
    input  mem_pkg::bank_req_t  req,
    output mem_pkg::bank_resp_t resp
);
    import mem_pkg::*;

    block_data_t blocks [BANK_BLOCKS];
    bank_req_t   pipe [MEM_DELAY];
    bank_req_t   tail;

    // Oldest entry, the one served this cycle
    assign tail = pipe[MEM_DELAY-1];

    // Fixed-latency delay line, one slot per cycle
    always_ff @(posedge clk or posedge init) begin
        if (init) begin
            for (int i = 0; i < MEM_DELAY; i++) begin
                pipe[i] <= '0;
            end
        end else begin
            pipe[0] <= req;
            for (int i = 1; i < MEM_DELAY; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    // Response takes the block as it was before any write below
    always_ff @(posedge clk or posedge init) begin
        if (init) begin
            resp <= '0;
        end else begin
            resp.valid      <= tail.valid;
            resp.cache_type <= tail.cache_type;
            if (tail.valid) begin
                resp.data <= blocks[tail.bank_addr];
            end else begin
                resp.data <= '0;
            end
        end
    end

    // Block array, cleared as a whole by init
    always_ff @(posedge clk or posedge init) begin
        if (init) begin
            for (int i = 0; i < BANK_BLOCKS; i++) begin
                blocks[i] <= '0;
            end
        end else if (tail.valid && (tail.req_type == WRITE)) begin
            // Whole-block write only
            blocks[tail.bank_addr] <= tail.data;
        end
    end

endmodule

/* mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                 clk,
    input  logic                 init,
    input  logic                 icache_req,
    input  mem_pkg::block_addr_t icache_addr,
    input  logic                 dcache_req,
    input  mem_pkg::dcache_req_t dcache_bundle,
    input  logic                 icache_ack,
    input  logic                 dcache_ack,
    output mem_pkg::bank_req_t   bank_req [mem_pkg::N_BANKS]
);
    import mem_pkg::*;

    client_phase_t              phase [N_CLIENTS];
    logic [N_CLIENTS-1:0]       client_req;
    logic [N_CLIENTS-1:0]       client_ack;
    logic [N_CLIENTS-1:0]       eligible;
    cache_type_t                last_grant;
    logic                       grant_valid;
    cache_type_t                grant_client;
    block_addr_t                grant_addr;
    logic [BANK_SEL_BITS-1:0]   grant_bank;
    bank_req_t                  next_req;

    // Client vectors indexed by cache_type
    assign client_req = {dcache_req, icache_req};
    assign client_ack = {dcache_ack, icache_ack};

    // Only a fresh req from an idle client counts
    always_comb begin
        for (int c = 0; c < N_CLIENTS; c++) begin
            eligible[c] = client_req[c] && (phase[c] == PH_IDLE);
        end
    end

    // Round-robin pick, the client not granted last wins a tie
    always_comb begin
        grant_valid = |eligible;
        if (&eligible) begin
            grant_client = (last_grant == ICACHE) ? DCACHE : ICACHE;
        end else if (eligible[DCACHE]) begin
            grant_client = DCACHE;
        end else begin
            grant_client = ICACHE;
        end
    end

    // Build the bank request for the winner
    always_comb begin
        if (grant_client == DCACHE) begin
            grant_addr        = dcache_bundle.addr;
            next_req.req_type = dcache_bundle.req_type;
            next_req.data     = dcache_bundle.data;
        end else begin
            // Icache only ever reads
            grant_addr        = icache_addr;
            next_req.req_type = READ;
            next_req.data     = '0;
        end
        next_req.valid      = grant_valid;
        next_req.cache_type = grant_client;
        next_req.bank_addr  = grant_addr[ADDR_BITS-1:BANK_SEL_BITS];
    end

    assign grant_bank = grant_addr[BANK_SEL_BITS-1:0];

    // One registered request per cycle, steered to its bank
    always_ff @(posedge clk or posedge init) begin
        if (init) begin
            for (int b = 0; b < N_BANKS; b++) begin
                bank_req[b] <= '0;
            end
        end else begin
            for (int b = 0; b < N_BANKS; b++) begin
                if (grant_valid && (grant_bank == BANK_SEL_BITS'(b))) begin
                    bank_req[b] <= next_req;
                end else begin
                    bank_req[b] <= '0;
                end
            end
        end
    end

    // Starts out favoring the icache
    always_ff @(posedge clk or posedge init) begin
        if (init) begin
            last_grant <= DCACHE;
        end else if (grant_valid) begin
            last_grant <= grant_client;
        end
    end

    // Phase per client: granted, then ack seen high, then ack seen low
    always_ff @(posedge clk or posedge init) begin
        if (init) begin
            for (int c = 0; c < N_CLIENTS; c++) begin
                phase[c] <= PH_IDLE;
            end
        end else begin
            for (int c = 0; c < N_CLIENTS; c++) begin
                case (phase[c])
                    PH_IDLE: begin
                        if (grant_valid && (grant_client == cache_type_t'(c))) begin
                            phase[c] <= PH_ISSUED;
                        end
                    end
                    PH_ISSUED: begin
                        if (client_ack[c]) begin
                            phase[c] <= PH_ACKED;
                        end
                    end
                    PH_ACKED: begin
                        if (!client_ack[c]) begin
                            phase[c] <= PH_IDLE;
                        end
                    end
                    default: begin
                        phase[c] <= PH_IDLE;
                    end
                endcase
            end
        end
    end

endmodule

/* mem_pkg.sv */
package mem_pkg;

    // Block and address geometry
    localparam int BLOCK_BITS    = 64;
    localparam int ADDR_BITS     = 10;
    localparam int BANK_SEL_BITS = 2;
    localparam int N_BANKS       = 4;
    localparam int BANK_BLOCKS   = 256;

    // Depth of the shift pipeline inside each bank
    localparam int MEM_DELAY = 5;

    // Icache and dcache
    localparam int N_CLIENTS = 2;

    typedef logic [BLOCK_BITS-1:0]              block_data_t;
    typedef logic [ADDR_BITS-1:0]               block_addr_t;
    // Upper bits of a block address, the low bits pick the bank
    typedef logic [ADDR_BITS-BANK_SEL_BITS-1:0] bank_addr_t;

    typedef enum logic {
        READ  = 1'b0,
        WRITE = 1'b1
    } req_type_t;

    // Also used as the client index in the arbiter and collector
    typedef enum logic {
        ICACHE = 1'b0,
        DCACHE = 1'b1
    } cache_type_t;

    // What the dcache presents with its req
    typedef struct packed {
        req_type_t   req_type;
        block_addr_t addr;
        block_data_t data;
    } dcache_req_t;

    // Arbiter to bank
    typedef struct packed {
        logic        valid;
        req_type_t   req_type;
        cache_type_t cache_type;
        bank_addr_t  bank_addr;
        block_data_t data;
    } bank_req_t;

    // Bank to collector
    typedef struct packed {
        logic        valid;
        cache_type_t cache_type;
        block_data_t data;
    } bank_resp_t;

    // Per-client handshake progress, seen by the arbiter
    typedef enum logic [1:0] {
        PH_IDLE   = 2'd0,
        PH_ISSUED = 2'd1,
        PH_ACKED  = 2'd2
    } client_phase_t;

endpackage

/* mem_resp_collect.sv */
`timescale 1ns/1ps

module mem_resp_collect (
    input  logic                 clk,
    input  logic                 init,
    input  mem_pkg::bank_resp_t  bank_resp [mem_pkg::N_BANKS],
    input  logic                 icache_req,
    input  logic                 dcache_req,
    output logic                 icache_ack,
    output logic                 dcache_ack,
    output mem_pkg::block_data_t icache_data,
    output mem_pkg::block_data_t dcache_data
);
    import mem_pkg::*;

    bank_resp_t           merged;
    logic [N_CLIENTS-1:0] client_req;
    logic [N_CLIENTS-1:0] hit;
    logic [N_CLIENTS-1:0] ack_q;
    block_data_t          data_q [N_CLIENTS];

    assign client_req = {dcache_req, icache_req};

    // At most one bank answers in a cycle since issue is one per cycle
    always_comb begin
        merged = '0;
        for (int b = 0; b < N_BANKS; b++) begin
            if (bank_resp[b].valid) begin
                merged = bank_resp[b];
            end
        end
    end

    // Which client the current response belongs to
    always_comb begin
        for (int c = 0; c < N_CLIENTS; c++) begin
            hit[c] = merged.valid && (merged.cache_type == cache_type_t'(c));
        end
    end

    // Ack rises with the response, falls once req is seen low
    always_ff @(posedge clk or posedge init) begin
        if (init) begin
            ack_q <= '0;
        end else begin
            for (int c = 0; c < N_CLIENTS; c++) begin
                if (hit[c]) begin
                    ack_q[c] <= 1'b1;
                end else if (!client_req[c]) begin
                    ack_q[c] <= 1'b0;
                end
            end
        end
    end

    // Only loaded on a response, so it stays put while ack is high
    always_ff @(posedge clk) begin
        for (int c = 0; c < N_CLIENTS; c++) begin
            if (hit[c]) begin
                data_q[c] <= merged.data;
            end
        end
    end

    assign icache_ack  = ack_q[ICACHE];
    assign dcache_ack  = ack_q[DCACHE];
    assign icache_data = data_q[ICACHE];
    assign dcache_data = data_q[DCACHE];

endmodule

/* mem_subsys.sv */
`timescale 1ns/1ps

module mem_subsys (
    input  logic                 clk,
    input  logic                 init,

    // Icache port, read only
    input  logic                 icache_req,
    input  mem_pkg::block_addr_t icache_addr,
    output logic                 icache_ack,
    output mem_pkg::block_data_t icache_data,

    // Dcache port
    input  logic                 dcache_req,
    input  mem_pkg::dcache_req_t dcache_bundle,
    output logic                 dcache_ack,
    output mem_pkg::block_data_t dcache_data
);
    import mem_pkg::*;

    bank_req_t  bank_req  [N_BANKS];
    bank_resp_t bank_resp [N_BANKS];

    // Arbiter watches req rising and the acks coming back
    mem_arbiter i_arbiter (
        .clk           (clk),
        .init          (init),
        .icache_req    (icache_req),
        .icache_addr   (icache_addr),
        .dcache_req    (dcache_req),
        .dcache_bundle (dcache_bundle),
        .icache_ack    (icache_ack),
        .dcache_ack    (dcache_ack),
        .bank_req      (bank_req)
    );

    // Low address bits interleave blocks across the banks
    for (genvar b = 0; b < N_BANKS; b++) begin : bank
        main_mem i_main_mem (
            .clk  (clk),
            .init (init),
            .req  (bank_req[b]),
            .resp (bank_resp[b])
        );
    end

    // Collector owns the acks and req falling
    mem_resp_collect i_collect (
        .clk         (clk),
        .init        (init),
        .bank_resp   (bank_resp),
        .icache_req  (icache_req),
        .dcache_req  (dcache_req),
        .icache_ack  (icache_ack),
        .dcache_ack  (dcache_ack),
        .icache_data (icache_data),
        .dcache_data (dcache_data)
    );

endmodule

/* tb.f */
mem_pkg.sv
mem_arbiter.sv
main_mem.sv
mem_resp_collect.sv
mem_subsys.sv
tb_mem_checker.sv
tb_mem_subsys.sv

/* tb_mem_checker.sv */
`timescale 1ns/1ps

module tb_mem_checker (
    input  logic                 clk,
    input  logic                 init,
    input  logic                 icache_ack,
    input  mem_pkg::block_data_t icache_data,
    input  logic                 dcache_ack,
    input  mem_pkg::block_data_t dcache_data,
    input  int                   row_idx,
    input  logic [127:0]         test_name,
    input  logic                 use_icache,
    input  logic                 use_dcache,
    input  mem_pkg::block_data_t exp_icache,
    input  mem_pkg::block_data_t exp_dcache,
    input  logic                 row_done,
    input  logic                 finished,
    output int                   n_pass,
    output int                   n_fail
);
    import mem_pkg::*;

    logic i_ack_q;
    logic d_ack_q;
    logic i_seen;
    logic d_seen;
    logic row_bad;

    initial begin
        n_pass  = 0;
        n_fail  = 0;
        i_ack_q = 1'b0;
        d_ack_q = 1'b0;
        i_seen  = 1'b0;
        d_seen  = 1'b0;
        row_bad = 1'b0;
    end

    // Leading zero bytes of the right-justified name are skipped
    function automatic string name_text(input logic [127:0] n);
        string s;
        s = "";
        for (int i = 15; i >= 0; i--) begin
            if (n[i*8 +: 8] != 8'h00) begin
                s = {s, $sformatf("%c", n[i*8 +: 8])};
            end
        end
        return s;
    endfunction

    // Acked data must match the table for as long as ack is high
    task automatic check_port(input string port, input logic used,
                              input block_data_t expected, input logic ack,
                              input logic ack_q, input block_data_t data);
        if (ack && !ack_q) begin
            if (!used) begin
                $display("Unexpected ack on the %s port during test %s",
                         port, name_text(test_name));
                row_bad = 1'b1;
            end else if (data !== expected) begin
                $display("FAIL %s %s expected %h actual %h",
                         name_text(test_name), port, expected, data);
                row_bad = 1'b1;
            end
        end else if (ack && used && (data !== expected)) begin
            $display("FAIL %s %s while ack held expected %h actual %h",
                     name_text(test_name), port, expected, data);
            row_bad = 1'b1;
        end
    endtask

    // Values seen here are the ones registered at the previous edge
    always @(posedge clk) begin
        check_port("icache", use_icache, exp_icache, icache_ack, i_ack_q,
                   icache_data);
        check_port("dcache", use_dcache, exp_dcache, dcache_ack, d_ack_q,
                   dcache_data);
        if (icache_ack && !i_ack_q) begin
            i_seen = 1'b1;
        end
        if (dcache_ack && !d_ack_q) begin
            d_seen = 1'b1;
        end
        i_ack_q = icache_ack;
        d_ack_q = dcache_ack;

        if (row_done) begin
            if (use_icache && !i_seen) begin
                $display("No ack came back on the icache port during test %s",
                         name_text(test_name));
                row_bad = 1'b1;
            end
            if (use_dcache && !d_seen) begin
                $display("No ack came back on the dcache port during test %s",
                         name_text(test_name));
                row_bad = 1'b1;
            end
            if (row_bad) begin
                n_fail = n_fail + 1;
            end else begin
                n_pass = n_pass + 1;
                $display("PASS %0d %s", row_idx, name_text(test_name));
            end
            row_bad = 1'b0;
            i_seen  = 1'b0;
            d_seen  = 1'b0;
        end
    end

    // Init clears the acks without waiting for a clock
    always @(posedge init) begin
        #1;
        if (icache_ack || dcache_ack) begin
            $display("An ack stayed high after init was asserted during test %s",
                     name_text(test_name));
            row_bad = 1'b1;
        end
    end

    always @(posedge finished) begin
        $display("Summary: %0d tests passed, %0d tests failed", n_pass, n_fail);
    end

endmodule

/* tb_mem_subsys.sv */
`timescale 1ns/1ps

module tb_mem_subsys;
    import mem_pkg::*;

    typedef enum logic [1:0] {
        SEL_I    = 2'd0,
        SEL_D    = 2'd1,
        SEL_BOTH = 2'd2,
        SEL_INIT = 2'd3
    } sel_t;

    // Icache takes addr in SEL_I rows and addr2 in all others
    typedef struct packed {
        logic [127:0] name;
        sel_t         sel;
        req_type_t    rtype;
        block_addr_t  addr;
        block_data_t  wdata;
        block_addr_t  addr2;
        block_data_t  exp_i;
        block_data_t  exp_d;
        logic [3:0]   hold;
    } row_t;

    localparam int N_ROWS      = 21;
    localparam int MAX_HOLD    = 6;
    localparam int CYCLE_LIMIT = N_ROWS * (MEM_DELAY + 4 + MAX_HOLD) * 2 + 50;

    localparam block_data_t D_A  = 64'h1111_2222_3333_4444;
    localparam block_data_t D_B  = 64'ha5a5_5a5a_0f0f_f0f0;
    localparam block_data_t D_C  = 64'h0123_4567_89ab_cdef;
    localparam block_data_t D_I0 = 64'h0000_0120_aaaa_0000;
    localparam block_data_t D_I1 = 64'h0000_0121_bbbb_1111;
    localparam block_data_t D_I2 = 64'h0000_0122_cccc_2222;
    localparam block_data_t D_I3 = 64'h0000_0123_dddd_3333;

    logic        clk;
    logic        init;
    logic        icache_req;
    block_addr_t icache_addr;
    logic        icache_ack;
    block_data_t icache_data;
    logic        dcache_req;
    dcache_req_t dcache_bundle;
    logic        dcache_ack;
    block_data_t dcache_data;

    row_t        rows [N_ROWS];
    row_t        cur_row;
    int          row_idx;
    logic        row_done;
    logic        finished;
    int          n_pass;
    int          n_fail;
    int          cycle_count;

    mem_subsys i_mem_subsys (
        .clk           (clk),
        .init          (init),
        .icache_req    (icache_req),
        .icache_addr   (icache_addr),
        .icache_ack    (icache_ack),
        .icache_data   (icache_data),
        .dcache_req    (dcache_req),
        .dcache_bundle (dcache_bundle),
        .dcache_ack    (dcache_ack),
        .dcache_data   (dcache_data)
    );

    tb_mem_checker i_checker (
        .clk         (clk),
        .init        (init),
        .icache_ack  (icache_ack),
        .icache_data (icache_data),
        .dcache_ack  (dcache_ack),
        .dcache_data (dcache_data),
        .row_idx     (row_idx),
        .test_name   (cur_row.name),
        .use_icache  (cur_row.sel != SEL_D),
        .use_dcache  (cur_row.sel != SEL_I),
        .exp_icache  (cur_row.exp_i),
        .exp_dcache  (cur_row.exp_d),
        .row_done    (row_done),
        .finished    (finished),
        .n_pass      (n_pass),
        .n_fail      (n_fail)
    );

    initial begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, a handshake never completed", cycle_count);
            $display("TESTS FAILED");
            $finish;
        end
    end

    function automatic row_t make_row(input logic [127:0] name, input sel_t sel,
                                      input req_type_t rtype, input block_addr_t addr,
                                      input block_data_t wdata, input block_addr_t addr2,
                                      input block_data_t exp_i, input block_data_t exp_d,
                                      input int hold);
        row_t r;
        r.name  = name;
        r.sel   = sel;
        r.rtype = rtype;
        r.addr  = addr;
        r.wdata = wdata;
        r.addr2 = addr2;
        r.exp_i = exp_i;
        r.exp_d = exp_d;
        r.hold  = hold[3:0];
        return r;
    endfunction

    task automatic fill_table();
        // Fresh memory reads zero in every bank
        rows[0]  = make_row("zero_b0_b1", SEL_BOTH, READ, 10'h000, '0, 10'h001, '0, '0, 0);
        rows[1]  = make_row("zero_b2_b3", SEL_BOTH, READ, 10'h3fe, '0, 10'h0ff, '0, '0, 0);
        // Write returns old contents
        rows[2]  = make_row("wr_new", SEL_D, WRITE, 10'h014, D_A, '0, '0, '0, 0);
        rows[3]  = make_row("wr_overwrite", SEL_D, WRITE, 10'h014, D_B, '0, '0, D_A, 0);
        rows[4]  = make_row("rd_d_back", SEL_D, READ, 10'h014, '0, '0, '0, D_B, 0);
        rows[5]  = make_row("rd_i_back", SEL_I, READ, 10'h014, '0, '0, D_B, '0, 0);
        // Neighbours in the low two bits go to different banks
        rows[6]  = make_row("wr_bank0", SEL_D, WRITE, 10'h120, D_I0, '0, '0, '0, 0);
        rows[7]  = make_row("wr_bank1", SEL_D, WRITE, 10'h121, D_I1, '0, '0, '0, 0);
        rows[8]  = make_row("wr_bank2", SEL_D, WRITE, 10'h122, D_I2, '0, '0, '0, 0);
        rows[9]  = make_row("wr_bank3", SEL_D, WRITE, 10'h123, D_I3, '0, '0, '0, 0);
        rows[10] = make_row("rd_bank0_1", SEL_BOTH, READ, 10'h120, '0, 10'h121, D_I1, D_I0, 0);
        rows[11] = make_row("rd_bank2_3", SEL_BOTH, READ, 10'h122, '0, 10'h123, D_I3, D_I2, 0);
        rows[12] = make_row("same_bank", SEL_BOTH, READ, 10'h124, '0, 10'h120, D_I0, '0, 0);
        rows[13] = make_row("wr_vs_rd", SEL_BOTH, WRITE, 10'h200, D_C, 10'h122, D_I2, '0, 0);
        // Icache holds its ack while the dcache finishes
        rows[14] = make_row("hold_icache", SEL_BOTH, READ, 10'h200, '0, 10'h121, D_I1, D_C, 6);
        rows[15] = make_row("after_hold", SEL_I, READ, 10'h123, '0, '0, D_I3, '0, 0);
        rows[16] = make_row("hold_dcache", SEL_D, READ, 10'h014, '0, '0, '0, D_B, 4);
        // Init mid-run with both acks high and zero reads afterwards
        rows[17] = make_row("init_mid", SEL_INIT, READ, 10'h014, '0, 10'h120, D_I0, D_B, 3);
        rows[18] = make_row("zero_after", SEL_BOTH, READ, 10'h014, '0, 10'h120, '0, '0, 0);
        rows[19] = make_row("zero_wr_old", SEL_D, WRITE, 10'h200, D_A, '0, '0, '0, 0);
        rows[20] = make_row("zero_i_bank3", SEL_I, READ, 10'h123, '0, '0, '0, '0, 0);
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic icache_access(input block_addr_t addr, input int hold);
        icache_addr = addr;
        icache_req  = 1'b1;
        next_cycle();
        while (!icache_ack) begin
            next_cycle();
        end
        repeat (hold) begin
            next_cycle();
        end
        icache_req = 1'b0;
        while (icache_ack) begin
            next_cycle();
        end
    endtask

    task automatic dcache_access(input req_type_t rtype, input block_addr_t addr,
                                 input block_data_t data, input int hold);
        dcache_bundle.req_type = rtype;
        dcache_bundle.addr     = addr;
        dcache_bundle.data     = data;
        dcache_req             = 1'b1;
        next_cycle();
        while (!dcache_ack) begin
            next_cycle();
        end
        repeat (hold) begin
            next_cycle();
        end
        dcache_req = 1'b0;
        while (dcache_ack) begin
            next_cycle();
        end
    endtask

    // Both clients still hold req when init rises and drop it before it falls
    task automatic init_when_acked();
        next_cycle();
        while (!(icache_ack && dcache_ack)) begin
            next_cycle();
        end
        // One more edge so the checker also samples the later ack high
        next_cycle();
        init = 1'b1;
        repeat (4) begin
            next_cycle();
        end
        init = 1'b0;
    endtask

    initial begin
        init          = 1'b1;
        icache_req    = 1'b0;
        icache_addr   = '0;
        dcache_req    = 1'b0;
        dcache_bundle = '0;
        cur_row       = '0;
        row_idx       = 0;
        row_done      = 1'b0;
        finished      = 1'b0;
        cycle_count   = 0;
        fill_table();
        repeat (4) begin
            @(posedge clk);
        end
        #1;
        init = 1'b0;

        for (int r = 0; r < N_ROWS; r++) begin
            next_cycle();
            cur_row = rows[r];
            row_idx = r;
            case (cur_row.sel)
                SEL_I: begin
                    icache_access(cur_row.addr, cur_row.hold);
                end
                SEL_D: begin
                    dcache_access(cur_row.rtype, cur_row.addr, cur_row.wdata, cur_row.hold);
                end
                SEL_BOTH: begin
                    fork
                        icache_access(cur_row.addr2, cur_row.hold);
                        dcache_access(cur_row.rtype, cur_row.addr, cur_row.wdata, 0);
                    join
                end
                default: begin
                    fork
                        icache_access(cur_row.addr2, cur_row.hold);
                        dcache_access(cur_row.rtype, cur_row.addr, cur_row.wdata,
                                      cur_row.hold);
                        init_when_acked();
                    join
                end
            endcase
            row_done = 1'b1;
            next_cycle();
            row_done = 1'b0;
        end

        finished = 1'b1;
        #1;
        if ((n_fail == 0) && (n_pass == N_ROWS)) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
